/* project.f */
+incdir+testbench
rtl/wb_pkg.sv
rtl/wb_fifo.sv
rtl/wb_spec_buffer.sv
rtl/wb_spec_fsm.sv
rtl/wb_arbiter.sv
rtl/writeback.sv
testbench/writeback_tb.sv

/* rtl/wb_arbiter.sv */
`timescale 1ns/1ps
// Routes arriving results to bypass or buffers and picks one buffered entry per cycle
// wb_out is combinational; the register file must accept a write every cycle

module wb_arbiter import wb_pkg::*; (
    input  logic  CLK,
    input  logic  nRST,
    input  prod_t alu,
    input  prod_t load,
    input  logic  spec_active,
    input  wb_t   alu_head,
    input  logic  alu_empty,
    input  logic  alu_clean_avail,
    input  wb_t   load_head,
    input  logic  load_empty,
    output logic  alu_write,
    output wb_t   alu_din,
    output logic  alu_read,
    output logic  load_write,
    output wb_t   load_din,
    output logic  load_read,
    output wb_t   wb_out
);

    logic bypass_ok;   // Nothing older is waiting and no branch is open
    logic alu_ok;      // ALU buffer has a clean head
    logic load_ok;     // Load buffer has a head
    logic alu_turn;    // Fair pick when both have data; 0 favours loads
    logic turn_flip;

    // Entries always carry the write strobe
    assign alu_din  = '{reg_en: 1'b1, reg_sel: alu.reg_sel, wdat: alu.wdat};
    assign load_din = '{reg_en: 1'b1, reg_sel: load.reg_sel, wdat: load.wdat};

    assign bypass_ok = alu_empty & load_empty & ~spec_active;
    assign alu_ok    = alu_clean_avail;
    assign load_ok   = ~load_empty;

    always_comb begin
        alu_write  = 1'b0;
        load_write = 1'b0;
        alu_read   = 1'b0;
        load_read  = 1'b0;
        turn_flip  = 1'b0;
        wb_out     = '0;
        if (bypass_ok) begin
            if (load.done) begin
                wb_out    = load_din;   // Load wins a tie
                alu_write = alu.done;   // ALU result parks in its buffer
            end else if (alu.done) begin
                wb_out = alu_din;
            end
        end else begin
            // Every arrival is buffered, speculative ALU results included
            alu_write  = alu.done;
            load_write = load.done;
            if (alu_ok && load_ok) begin
                turn_flip = 1'b1;
                if (alu_turn) begin
                    alu_read = 1'b1;
                    wb_out   = alu_head;
                end else begin
                    load_read = 1'b1;
                    wb_out    = load_head;
                end
            end else if (alu_ok) begin
                alu_read = 1'b1;
                wb_out   = alu_head;
            end else if (load_ok) begin
                load_read = 1'b1;
                wb_out    = load_head;
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            alu_turn <= 1'b0;
        end else if (turn_flip) begin
            alu_turn <= ~alu_turn;  // Only contested picks move the toggle
        end
    end

endmodule

/* rtl/wb_fifo.sv */
`timescale 1ns/1ps
// Circular buffer for load results; head entry is shown combinationally on dout
// Empty and full are registered, so a new entry is readable one cycle after its write
// No back-pressure exists; the user must keep the buffer from overflowing

module wb_fifo import wb_pkg::*; #(
    parameter int BUFFER_DEPTH = 31
) (
    input  logic CLK,
    input  logic nRST,
    input  logic write,
    input  wb_t  din,
    input  logic read,
    output wb_t  dout,
    output logic empty,
    output logic full
);

    localparam int PTR_W = $clog2(BUFFER_DEPTH);
    localparam int CNT_W = $clog2(BUFFER_DEPTH + 1);  // Must hold the value BUFFER_DEPTH

    wb_t              mem [BUFFER_DEPTH];  // Entry storage
    logic [PTR_W-1:0] wptr, rptr;
    logic [CNT_W-1:0] count, count_next;

    // Pointer advance with wrap at the last slot
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(BUFFER_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign count_next = count + CNT_W'(write) - CNT_W'(read);  // Read and write may coincide
    assign dout       = mem[rptr];                             // Oldest entry

    always_ff @(posedge CLK) begin
        if (write) begin
            mem[wptr] <= din;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
            empty <= 1'b1;
            full  <= 1'b0;
        end else begin
            if (write) begin
                wptr <= ptr_inc(wptr);
            end
            if (read) begin
                rptr <= ptr_inc(rptr);
            end
            count <= count_next;
            // Flags follow the count of the next cycle
            empty <= (count_next == '0);
            full  <= (count_next == CNT_W'(BUFFER_DEPTH));
        end
    end

    // Producers have no stall, so overflow means the depth is too small
    a_no_write_full: assert property (@(posedge CLK) disable iff (!nRST)
        write |-> !full)
        else $error("wb_fifo: write while full");

    // The arbiter must only read a buffer that reports data
    a_no_read_empty: assert property (@(posedge CLK) disable iff (!nRST)
        read |-> !empty)
        else $error("wb_fifo: read while empty");

endmodule

/* rtl/wb_pkg.sv */
// Shared types for the writeback stage
// Struct field order sets the packed bit layout seen by the testbench

package wb_pkg;

    localparam int REG_SEL_W = 5;   // Register file has 32 entries
    localparam int WORD_W    = 32;  // Data word width

    // One register-file write, also the entry format of both buffers
    typedef struct packed {
        logic                 reg_en;   // Write strobe
        logic [REG_SEL_W-1:0] reg_sel;  // Destination register
        logic [WORD_W-1:0]    wdat;     // Data word
    } wb_t;

    // Result from the ALU or the load unit; done is a single-cycle strobe
    typedef struct packed {
        logic                 done;
        logic [REG_SEL_W-1:0] reg_sel;
        logic [WORD_W-1:0]    wdat;
    } prod_t;

    // Branch unit outputs
    typedef struct packed {
        logic spec;        // High while a branch is unresolved
        logic correct;     // Pulse when the prediction held
        logic mispredict;  // Pulse when the prediction failed
    } branch_t;

    // Speculation tracking state
    typedef enum logic {
        IDLE = 1'b0,  // No branch in flight
        SPEC = 1'b1   // ALU results are held back
    } spec_state_t;

endpackage

/* rtl/wb_spec_buffer.sv */
`timescale 1ns/1ps
// Circular buffer for ALU results with a speculation checkpoint
// Only clean entries may be read; speculative ones wait for commit or squash
// One speculation level is tracked; a nested branch is not supported

module wb_spec_buffer import wb_pkg::*; #(
    parameter int BUFFER_DEPTH = 31
) (
    input  logic CLK,
    input  logic nRST,
    input  logic write,
    input  wb_t  din,
    input  logic read,
    output wb_t  dout,
    input  logic spec_start,
    input  logic commit,
    input  logic squash,
    input  logic spec_active,
    output logic empty,
    output logic clean_avail,
    output logic full
);

    localparam int PTR_W = $clog2(BUFFER_DEPTH);
    localparam int CNT_W = $clog2(BUFFER_DEPTH + 1);

    wb_t              mem [BUFFER_DEPTH];  // Entry storage
    logic [PTR_W-1:0] wptr, rptr, chk_wptr;
    logic [PTR_W-1:0] wptr_next;
    logic [CNT_W-1:0] count, spec_cnt, clean_cnt;          // All, speculative, clean entries
    logic [CNT_W-1:0] count_next, spec_next, clean_next;
    logic             spec_wr, clean_wr;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(BUFFER_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign spec_wr  = write & spec_active;   // Held back until the branch resolves
    assign clean_wr = write & ~spec_active;  // Readable from the next cycle
    assign dout     = mem[rptr];

    always_comb begin
        wptr_next  = write ? ptr_inc(wptr) : wptr;
        count_next = count + CNT_W'(write) - CNT_W'(read);
        spec_next  = spec_cnt + CNT_W'(spec_wr);
        clean_next = clean_cnt + CNT_W'(clean_wr) - CNT_W'(read);
        if (commit) begin
            // Every speculative entry and this cycle's write turn clean
            clean_next = clean_cnt - CNT_W'(read) + spec_cnt + CNT_W'(spec_wr);
            spec_next  = '0;
        end else if (squash) begin
            // Drop everything written since the checkpoint
            wptr_next  = chk_wptr;
            count_next = count - CNT_W'(read) - spec_cnt;  // Squash-cycle write never counted
            spec_next  = '0;
        end
    end

    always_ff @(posedge CLK) begin
        if (write) begin
            mem[wptr] <= din;  // A squashed slot is simply overwritten later
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wptr        <= '0;
            rptr        <= '0;
            chk_wptr    <= '0;
            count       <= '0;
            spec_cnt    <= '0;
            clean_cnt   <= '0;
            empty       <= 1'b1;
            clean_avail <= 1'b0;
            full        <= 1'b0;
        end else begin
            wptr <= wptr_next;
            if (read) begin
                rptr <= ptr_inc(rptr);
            end
            if (spec_start) begin
                chk_wptr <= wptr;  // First speculative slot
            end
            count     <= count_next;
            spec_cnt  <= spec_next;
            clean_cnt <= clean_next;
            // Registered status
            empty       <= (count_next == '0);  // Speculative entries count as present
            clean_avail <= (clean_next != '0);
            full        <= (count_next == CNT_W'(BUFFER_DEPTH));
        end
    end

    // Speculative data must never reach the register file
    a_read_clean: assert property (@(posedge CLK) disable iff (!nRST)
        read |-> clean_avail)
        else $error("wb_spec_buffer: read without a clean entry");

    a_no_write_full: assert property (@(posedge CLK) disable iff (!nRST)
        write |-> !full)
        else $error("wb_spec_buffer: write while full");

    // Branch unit resolves a branch exactly one way
    a_one_outcome: assert property (@(posedge CLK) disable iff (!nRST)
        !(commit && squash))
        else $error("wb_spec_buffer: commit and squash together");

endmodule

/* rtl/wb_spec_fsm.sv */
`timescale 1ns/1ps
// Speculation tracker; spec_start is combinational on the rising spec edge
// Branch outcomes are expected only while a branch is tracked

module wb_spec_fsm import wb_pkg::*; (
    input  logic    CLK,
    input  logic    nRST,
    input  branch_t branch,
    output logic    spec_start,
    output logic    spec_active,
    output logic    commit,
    output logic    squash
);

    spec_state_t state, state_next;
    logic        prev_spec;  // Spec level of the previous cycle

    assign spec_start  = branch.spec & ~prev_spec;         // Rising edge of spec
    assign commit      = branch.correct & (state == SPEC);
    assign squash      = branch.mispredict & (state == SPEC);
    assign spec_active = (state == SPEC) | spec_start;      // Covers the start cycle too

    always_comb begin
        state_next = state;
        case (state)
            IDLE: if (spec_start) state_next = SPEC;
            SPEC: if (commit || squash) state_next = IDLE;  // Leaves one edge after outcome
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= IDLE;
            prev_spec <= 1'b0;
        end else begin
            state     <= state_next;
            prev_spec <= branch.spec;
        end
    end

    // An outcome with no branch tracked would leave speculative ALU data stranded
    a_outcome_in_spec: assert property (@(posedge CLK) disable iff (!nRST)
        (branch.correct || branch.mispredict) |-> (state == SPEC))
        else $error("wb_spec_fsm: branch outcome while idle");

endmodule

/* rtl/writeback.sv */
`timescale 1ns/1ps
// Writeback stage top; at most one register-file write per cycle
// BUFFER_DEPTH sets both buffers and must be 2 or more
// No stall goes back to the producers, so the depth must cover the worst burst

module writeback import wb_pkg::*; #(
    parameter int BUFFER_DEPTH = 31
) (
    input  logic    CLK,
    input  logic    nRST,
    input  prod_t   alu,
    input  prod_t   load,
    input  branch_t branch,
    output wb_t     wb_out
);

    logic spec_start, spec_active, commit, squash;  // Speculation control
    logic alu_write, alu_read, load_write, load_read;
    wb_t  alu_din, load_din, alu_head, load_head;
    logic alu_empty, alu_clean_avail, load_empty;

    wb_spec_fsm spec_fsm_inst (
        .CLK, .nRST, .branch,
        .spec_start, .spec_active, .commit, .squash
    );

    // Load buffer, never speculative
    wb_fifo #(.BUFFER_DEPTH(BUFFER_DEPTH)) load_fifo_inst (
        .CLK, .nRST,
        .write(load_write), .din(load_din), .read(load_read), .dout(load_head),
        .empty(load_empty), .full()  // Full is checked inside the buffer
    );

    // ALU buffer with checkpoint and rollback
    wb_spec_buffer #(.BUFFER_DEPTH(BUFFER_DEPTH)) alu_buffer_inst (
        .CLK, .nRST,
        .write(alu_write), .din(alu_din), .read(alu_read), .dout(alu_head),
        .spec_start, .commit, .squash, .spec_active,
        .empty(alu_empty), .clean_avail(alu_clean_avail), .full()
    );

    wb_arbiter arbiter_inst (
        .CLK, .nRST, .alu, .load, .spec_active,
        .alu_head, .alu_empty, .alu_clean_avail,
        .load_head, .load_empty,
        .alu_write, .alu_din, .alu_read,
        .load_write, .load_din, .load_read,
        .wb_out
    );

endmodule

/* testbench/wb_model.svh */
// Reference model of the writeback stage, included inside the testbench module
// Tracks one open branch at a time from the driven branch signals
// Queues hold expected entries per source; order inside a queue is the leave order
`ifndef WB_MODEL_SVH
`define WB_MODEL_SVH

wb_t         alu_q[$];            // Clean ALU entries still to be written back
wb_t         spec_q[$];           // ALU entries held by an open branch
wb_t         load_q[$];           // Load entries still to be written back
wb_t         dropped_q[$];        // Squashed ALU entries, never expected
spec_state_t state_m = IDLE;
logic        prev_spec_m = 1'b0;  // Spec level seen in the last cycle

// Applies one cycle of inputs and returns the entry that must bypass now, or all zero
function automatic wb_t predict_cycle(input prod_t a, input prod_t l, input branch_t b);
    wb_t  a_ent;
    wb_t  l_ent;
    wb_t  byp;
    logic start;
    logic active;
    logic commit;
    logic squash;
    logic all_empty;
    a_ent     = '{reg_en: 1'b1, reg_sel: a.reg_sel, wdat: a.wdat};
    l_ent     = '{reg_en: 1'b1, reg_sel: l.reg_sel, wdat: l.wdat};
    byp       = '0;
    start     = b.spec && !prev_spec_m;        // Rising spec edge
    active    = (state_m == SPEC) || start;
    commit    = b.correct && (state_m == SPEC);
    squash    = b.mispredict && (state_m == SPEC);
    all_empty = (alu_q.size() == 0) && (spec_q.size() == 0) && (load_q.size() == 0);
    if (all_empty && !active) begin
        if (l.done)
            byp = l_ent;  // Load goes first on a tie
        else if (a.done)
            byp = a_ent;
    end
    if (l.done)
        load_q.push_back(l_ent);
    if (a.done) begin
        if (active)
            spec_q.push_back(a_ent);  // Resolve-cycle results are speculative too
        else
            alu_q.push_back(a_ent);
    end
    if (commit) begin
        while (spec_q.size() > 0)
            alu_q.push_back(spec_q.pop_front());
    end else if (squash) begin
        while (spec_q.size() > 0)
            dropped_q.push_back(spec_q.pop_front());
    end
    if (state_m == IDLE && start)
        state_m = SPEC;
    else if (state_m == SPEC && (commit || squash))
        state_m = IDLE;
    prev_spec_m = b.spec;
    return byp;
endfunction

function automatic logic was_dropped(input wb_t w);
    foreach (dropped_q[i]) begin
        if (dropped_q[i] == w)
            return 1'b1;
    end
    return 1'b0;
endfunction

`endif

/* testbench/writeback_tb.sv */
`timescale 1ns/1ps
// Testbench for the writeback stage with buffers of depth 8
// Random stimulus keeps each buffer below full, since the stage has no back-pressure
// Data bit 31 tags the source (1 for load); the low bits hold a sequence number

module writeback_tb import wb_pkg::*; ();

    localparam int      DEPTH       = 8;
    localparam int      DRAIN_LIMIT = 200;   // Cycles allowed for the queues to empty
    localparam prod_t   NO_RESULT   = '0;
    localparam branch_t NO_BRANCH   = 3'b000;
    localparam branch_t BR_SPEC     = 3'b100;  // Branch open
    localparam branch_t BR_RIGHT    = 3'b110;  // Open, prediction held
    localparam branch_t BR_WRONG    = 3'b101;  // Open, mispredicted

    logic    CLK;
    logic    nRST;
    prod_t   alu_in;
    prod_t   load_in;
    branch_t branch_in;
    wb_t     wb_out;

    int   seed = 20;
    int   seq_num;
    int   errors;
    int   test_err_start;
    int   tests_run;
    int   tests_failed;
    wb_t  exp_bypass;              // Expected same-cycle write, from the model
    int   alu_ready;               // Queue sizes at the start of the cycle
    int   load_ready;
    logic last_src;                // Source of the last contested read
    logic have_last;

    `include "wb_model.svh"

    writeback #(.BUFFER_DEPTH(DEPTH)) writeback_inst (
        .CLK, .nRST,
        .alu(alu_in), .load(load_in), .branch(branch_in),
        .wb_out
    );

    always #10 CLK = ~CLK;  // 20 ns period

    task automatic report_error(input string msg);
        $display("error at time %0t: %s", $time, msg);
        errors++;
    endtask

    function automatic prod_t make_result(input logic is_load);
        prod_t p;
        p.done              = 1'b1;
        p.reg_sel           = REG_SEL_W'($random(seed));
        p.wdat              = seq_num;
        p.wdat[WORD_W-1]    = is_load;  // Source tag
        seq_num++;
        return p;
    endfunction

    // Inputs change 1 ns after the edge; the model sees them at the same moment
    task automatic drive_cycle(input prod_t a, input prod_t l, input branch_t b);
        @(posedge CLK);
        #1;
        alu_in     = a;
        load_in    = l;
        branch_in  = b;
        exp_bypass = predict_cycle(a, l, b);
    endtask

    // Outputs are combinational, so they are settled by the falling edge
    task automatic check_cycle();
        logic src;
        if (exp_bypass.reg_en) begin
            assert (wb_out == exp_bypass)
                else report_error($sformatf("bypass of %h missing", exp_bypass.wdat));
        end
        if (alu_ready > 0 || load_ready > 0) begin
            assert (wb_out.reg_en) else report_error("no write while an entry was waiting");
        end
        if (wb_out.reg_en) begin
            src = wb_out.wdat[WORD_W-1];
            if (src) begin
                assert (load_q.size() > 0 && wb_out == load_q[0])
                    else report_error($sformatf("load write %h out of order", wb_out.wdat));
                if (load_q.size() > 0)
                    void'(load_q.pop_front());
            end else begin
                assert (!was_dropped(wb_out))
                    else report_error($sformatf("squashed ALU %h written", wb_out.wdat));
                assert (alu_q.size() > 0 && wb_out == alu_q[0])
                    else report_error($sformatf("ALU write %h out of order", wb_out.wdat));
                if (alu_q.size() > 0)
                    void'(alu_q.pop_front());
            end
            // Both buffers readable, so the pick must alternate
            if (alu_ready > 0 && load_ready > 0) begin
                assert (!have_last || src != last_src)
                    else report_error("contested reads did not alternate");
                last_src  = src;
                have_last = 1'b1;
            end
        end
    endtask

    // Output checker, runs at every falling edge after reset
    always begin
        @(posedge CLK);
        alu_ready  = alu_q.size();
        load_ready = load_q.size();
        @(negedge CLK);
        if (nRST)
            check_cycle();
    end

    task automatic wait_drain(input string name);
        int cycles;
        cycles = 0;
        while ((alu_q.size() > 0 || load_q.size() > 0 || spec_q.size() > 0)
               && cycles < DRAIN_LIMIT) begin
            drive_cycle(NO_RESULT, NO_RESULT, NO_BRANCH);
            cycles++;
        end
        if (alu_q.size() > 0 || load_q.size() > 0 || spec_q.size() > 0) begin
            $display("Timeout in test %s, expected writes still missing after %0d cycles",
                     name, DRAIN_LIMIT);
            errors++;
        end
    endtask

    // Opens a branch for len cycles, then resolves it with an ALU result in that cycle
    task automatic run_branch(input logic correct, input int len);
        int k;
        for (k = 0; k < len; k++)
            drive_cycle(make_result(1'b0), (k % 2 == 1) ? make_result(1'b1) : NO_RESULT, BR_SPEC);
        drive_cycle(make_result(1'b0), NO_RESULT, correct ? BR_RIGHT : BR_WRONG);
        drive_cycle(NO_RESULT, NO_RESULT, NO_BRANCH);  // Spec drops after the outcome
    endtask

    task automatic start_test();
        test_err_start = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors > test_err_start) begin
            tests_failed++;
            $display("Test %0d %s: failed, %0d errors", tests_run, name, errors - test_err_start);
        end else begin
            $display("Test %0d %s: passed", tests_run, name);
        end
    endtask

    initial begin
        int    i;
        prod_t a;
        prod_t l;
        CLK          = 1'b0;
        nRST         = 1'b0;
        alu_in       = NO_RESULT;
        load_in      = NO_RESULT;
        branch_in    = NO_BRANCH;
        exp_bypass   = '0;
        seq_num      = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        have_last    = 1'b0;
        last_src     = 1'b0;
        repeat (4) @(posedge CLK);
        #1 nRST = 1'b1;

        start_test();
        for (i = 0; i < 10; i++) begin
            drive_cycle(NO_RESULT, NO_RESULT, NO_BRANCH);
            @(negedge CLK);
            assert (!wb_out.reg_en) else report_error("write strobe high with no input");
        end
        end_test("idle after reset");

        start_test();
        drive_cycle(make_result(1'b0), NO_RESULT, NO_BRANCH);   // Single ALU bypass
        wait_drain("bypass");
        drive_cycle(NO_RESULT, make_result(1'b1), NO_BRANCH);   // Single load bypass
        wait_drain("bypass");
        drive_cycle(make_result(1'b0), make_result(1'b1), NO_BRANCH);  // Tie
        wait_drain("bypass");
        end_test("bypass");

        start_test();
        for (i = 0; i < 150; i++) begin
            a = NO_RESULT;
            l = NO_RESULT;
            if ((($random(seed) & 1) == 1) && (alu_q.size() + spec_q.size() < DEPTH - 1))
                a = make_result(1'b0);
            if ((($random(seed) & 1) == 1) && (load_q.size() < DEPTH - 1))
                l = make_result(1'b1);
            drive_cycle(a, l, NO_BRANCH);
        end
        wait_drain("random stream");
        end_test("random stream");

        start_test();
        run_branch(1'b1, 5);
        wait_drain("commit");
        end_test("commit");

        start_test();
        drive_cycle(make_result(1'b0), make_result(1'b1), NO_BRANCH);  // Clean ALU parked
        drive_cycle(make_result(1'b0), make_result(1'b1), NO_BRANCH);
        run_branch(1'b0, 5);
        for (i = 0; i < 3; i++)
            drive_cycle(make_result(1'b0), NO_RESULT, NO_BRANCH);   // Normal again
        wait_drain("squash");
        drive_cycle(make_result(1'b0), NO_RESULT, NO_BRANCH);  // Rolled-back buffer bypasses again
        wait_drain("squash");
        end_test("squash");

        $display("Tests run: %0d, passed: %0d, failed: %0d, failed checks: %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
